//--- build.f
+incdir+.
rename_pkg.sv
rename_rat.sv
rename_free_list.sv
rename_rob.sv
rename_rrf.sv
rename_ready_table.sv
rename_prf.sv
rename_core.sv
tb_rename_core.sv

//--- Bender.yml
package:
  name: rename_core

export_include_dirs:
  - .

sources:
  - rename_pkg.sv
  - rename_rat.sv
  - rename_free_list.sv
  - rename_rob.sv
  - rename_rrf.sv
  - rename_ready_table.sv
  - rename_prf.sv
  - rename_core.sv
  - target: test
    files:
      - tb_rename_core.sv

//--- tb_rename_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module tb_rename_core;
    import rename_pkg::*;

    localparam int TOTAL_INSTR     = 4 + 40 + 5 + 16 + 68;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 40 + 1000;

    // One in-flight instruction as the model sees it
    typedef struct packed {
        rob_idx_t  rob;
        arch_idx_t rd;
        logic      renames;
        phys_idx_t prd;
        logic      done;
        logic      redirect;
        xlen_t     data;
    } entry_t;

    logic        clk;
    logic        rst;
    disp_req_t   i_disp;
    cdb_t        i_cdb;
    disp_rsp_t   o_disp_rsp;
    commit_t     o_commit;
    credit_cnt_t o_credit_ret;

    entry_t    inflight [$];
    phys_idx_t spec_map [`RN_ARCH_REGS];
    phys_idx_t comm_map [`RN_ARCH_REGS];
    int        credits;
    int        tail;
    int        exp_fresh;
    int        errors;
    int        test_errors;
    int        tests_passed;
    int        tests_failed;
    int        seed;
    string     cur_test;
    disp_req_t no_disp = '0;
    cdb_t      no_cdb = '0;

    rename_core u_rename_core (
        .clk,
        .rst,
        .i_disp,
        .i_cdb,
        .o_disp_rsp,
        .o_commit,
        .o_credit_ret
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    // No credits come back without a commit
    assert property (@(posedge clk) disable iff (rst) !o_commit.valid |-> (o_credit_ret == '0))
        else begin
            $display("Credits returned in a cycle without a commit");
            errors++;
        end

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("FAIL %s %s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    function automatic bit preg_ready(input phys_idx_t p, input cdb_t c);
        bit rdy;
        rdy = 1'b1;
        foreach (inflight[i]) begin
            if (inflight[i].renames && inflight[i].prd == p && !inflight[i].done) rdy = 1'b0;
        end
        if (c.valid && c.prd == p) rdy = 1'b1;
        return rdy || (p == '0);
    endfunction

    function automatic bit preg_in_use(input phys_idx_t p);
        bit used;
        used = 1'b0;
        foreach (inflight[i]) begin
            if (inflight[i].renames && inflight[i].prd == p) used = 1'b1;
        end
        for (int a = 0; a < `RN_ARCH_REGS; a++) begin
            if (comm_map[a] == p) used = 1'b1;
        end
        return used;
    endfunction

    function automatic disp_req_t mk_disp(input int rs1, input int rs2, input int rd,
                                          input bit writes);
        disp_req_t d;
        d.valid     = 1'b1;
        d.rs1       = arch_idx_t'(rs1);
        d.rs2       = arch_idx_t'(rs2);
        d.rd        = arch_idx_t'(rd);
        d.writes_rd = writes;
        return d;
    endfunction

    function automatic cdb_t mk_cdb(input int idx, input bit redirect);
        cdb_t c;
        c.valid    = 1'b1;
        c.rob_idx  = inflight[idx].rob;
        c.prd      = inflight[idx].prd;
        c.data     = $random(seed);
        c.redirect = redirect;
        return c;
    endfunction

    function automatic int pick_pending();
        int idx [$];
        foreach (inflight[i]) begin
            if (!inflight[i].done) idx.push_back(i);
        end
        if (idx.size() == 0) return -1;
        return idx[$unsigned($random(seed)) % idx.size()];
    endfunction

    // Drive one cycle, check the DUT against the model, then advance the model
    task automatic step(input disp_req_t d, input cdb_t c);
        bit     commit_exp;
        bit     flush_exp;
        int     ret_exp;
        entry_t head;
        entry_t e;
        @(posedge clk);
        i_disp <= d;
        i_cdb  <= c;
        @(negedge clk);
        commit_exp = (inflight.size() > 0) && inflight[0].done;
        flush_exp  = commit_exp && inflight[0].redirect;
        ret_exp    = !commit_exp ? 0 : (flush_exp ? inflight.size() : 1);
        check_val("commit valid", commit_exp, o_commit.valid);
        check_val("credit return", ret_exp, o_credit_ret);
        if (commit_exp) begin
            head = inflight[0];
            check_val("commit rd", head.rd, o_commit.rd);
            check_val("commit writes_rd", head.renames, o_commit.writes_rd);
            check_val("commit data", head.renames ? head.data : '0, o_commit.data);
            check_val("commit redirect", head.redirect, o_commit.redirect);
        end
        e.renames = d.writes_rd && (d.rd != '0);
        if (d.valid && !flush_exp) begin
            check_val("rob_idx", tail, o_disp_rsp.rob_idx);
            check_val("prs1", spec_map[d.rs1], o_disp_rsp.prs1);
            check_val("prs2", spec_map[d.rs2], o_disp_rsp.prs2);
            check_val("rs1_ready", preg_ready(spec_map[d.rs1], c), o_disp_rsp.rs1_ready);
            check_val("rs2_ready", preg_ready(spec_map[d.rs2], c), o_disp_rsp.rs2_ready);
            if (!e.renames) begin
                check_val("prd", 0, o_disp_rsp.prd);
            end else begin
                if (exp_fresh >= 0) begin
                    check_val("prd", exp_fresh, o_disp_rsp.prd);
                    exp_fresh++;
                end
                assert (o_disp_rsp.prd != '0 && !preg_in_use(o_disp_rsp.prd)) else begin
                    $display("Physical register %0d handed out while in use", o_disp_rsp.prd);
                    errors++;
                end
            end
        end
        credits += o_credit_ret;
        if (commit_exp) begin
            head = inflight.pop_front();
            if (head.renames) comm_map[head.rd] = head.prd;
            if (flush_exp) begin
                inflight.delete();
                spec_map = comm_map;
                tail     = 0;
            end
        end
        if (c.valid && !flush_exp) begin
            foreach (inflight[i]) begin
                if (inflight[i].rob == c.rob_idx) begin
                    inflight[i].done     = 1'b1;
                    inflight[i].redirect = c.redirect;
                    inflight[i].data     = c.data;
                end
            end
        end
        if (d.valid && !flush_exp) begin
            e.rob      = rob_idx_t'(tail);
            e.rd       = d.rd;
            e.prd      = o_disp_rsp.prd;
            e.done     = 1'b0;
            e.redirect = 1'b0;
            e.data     = '0;
            inflight.push_back(e);
            if (e.renames) spec_map[d.rd] = e.prd;
            tail = (tail + 1) % `RN_ROB_DEPTH;
            credits--;
        end
        assert (credits >= 0 && credits <= `RN_ROB_DEPTH) else begin
            $display("Dispatcher credit count left its range at %0d", credits);
            errors++;
        end
    endtask

    // Complete the oldest pending instruction each cycle until the ROB is empty
    task automatic drain();
        int   k;
        cdb_t c;
        while (inflight.size() > 0) begin
            k = -1;
            foreach (inflight[i]) begin
                if (k < 0 && !inflight[i].done) k = i;
            end
            c = (k >= 0) ? mk_cdb(k, 1'b0) : no_cdb;
            step(no_disp, c);
        end
    endtask

    task automatic run_random(input int n, input int redirect_pct);
        int        left;
        int        k;
        bit        redir;
        disp_req_t d;
        cdb_t      c;
        left = n;
        while (left > 0 || inflight.size() > 0) begin
            d = no_disp;
            c = no_cdb;
            if (left > 0 && credits > 0 && ($random(seed) & 3) != 0) begin
                d = mk_disp($random(seed) & 31, $random(seed) & 31, $random(seed) & 31,
                            ($random(seed) & 7) != 0);
                left--;
            end
            k = pick_pending();
            if (k >= 0 && ($random(seed) & 1)) begin
                redir = ($unsigned($random(seed)) % 100) < redirect_pct;
                c = mk_cdb(k, redir);
            end
            step(d, c);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            $display("test %s: ok", cur_test);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", cur_test, errors - test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        seed         = 32'hb8c43c7a;
        rst          = 1'b1;
        i_disp       = '0;
        i_cdb        = '0;
        credits      = `RN_ROB_DEPTH;
        tail         = 0;
        exp_fresh    = -1;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int a = 0; a < `RN_ARCH_REGS; a++) begin
            spec_map[a] = phys_idx_t'(a);
            comm_map[a] = phys_idx_t'(a);
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset_state");
        repeat (3) step(no_disp, no_cdb);
        exp_fresh = `RN_ARCH_REGS;
        // Sources never renamed yet, so identity mapped and ready
        for (int i = 1; i <= 4; i++) begin
            step(mk_disp(i + 8, i + 16, i, 1'b1), no_cdb);
        end
        exp_fresh = -1;
        step(no_disp, no_cdb);
        drain();
        end_test();

        begin_test("commit_order");
        run_random(40, 0);
        end_test();

        begin_test("renaming_readiness");
        step(mk_disp(0, 0, 5, 1'b1), no_cdb);
        step(mk_disp(5, 6, 7, 1'b1), no_cdb);
        // Producer of x5 completes alongside this dispatch
        step(mk_disp(5, 5, 9, 1'b1), mk_cdb(0, 1'b0));
        step(mk_disp(5, 7, 5, 1'b1), no_cdb);
        drain();
        step(mk_disp(5, 9, 0, 1'b0), no_cdb);
        drain();
        end_test();

        begin_test("credit_exhaustion");
        for (int i = 0; i < `RN_ROB_DEPTH; i++) begin
            step(mk_disp($random(seed) & 31, $random(seed) & 31,
                         1 + ($unsigned($random(seed)) % 31), 1'b1), no_cdb);
        end
        check_val("credits", 0, credits);
        step(no_disp, mk_cdb(0, 1'b0));
        step(no_disp, no_cdb);
        check_val("credits", 1, credits);
        drain();
        check_val("credits", `RN_ROB_DEPTH, credits);
        end_test();

        begin_test("redirect_flush");
        for (int i = 10; i < 16; i++) begin
            step(mk_disp($random(seed) & 31, $random(seed) & 31, i, 1'b1), no_cdb);
        end
        // Third instruction mispredicts, squashing the three after it
        step(no_disp, mk_cdb(2, 1'b1));
        drain();
        step(mk_disp(10, 12, 16, 1'b1), no_cdb);
        step(mk_disp(13, 11, 17, 1'b1), no_cdb);
        drain();
        run_random(60, 10);
        end_test();

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rename_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_core (
    input  logic                    clk,
    input  logic                    rst,
    input  rename_pkg::disp_req_t   i_disp,
    input  rename_pkg::cdb_t        i_cdb,
    output rename_pkg::disp_rsp_t   o_disp_rsp,
    output rename_pkg::commit_t     o_commit,
    output rename_pkg::credit_cnt_t o_credit_ret
);
    import rename_pkg::*;

    // Rename
    phys_idx_t rat_prs1;
    phys_idx_t rat_prs2;
    phys_idx_t rat_old_prd;
    phys_idx_t fl_head_preg;

    // ROB
    rob_idx_t  rob_idx;
    logic      rn_alloc;
    logic      commit_en;
    arch_idx_t commit_rd;
    phys_idx_t commit_prd;
    logic      free_push;
    phys_idx_t free_preg;
    logic      flush;

    // Retirement and readiness
    phys_idx_t rrf_map [`RN_ARCH_REGS];
    logic      rs1_ready;
    logic      rs2_ready;
    xlen_t     commit_data;

    assign o_disp_rsp.rob_idx   = rob_idx;
    assign o_disp_rsp.prs1      = rat_prs1;
    assign o_disp_rsp.prs2      = rat_prs2;
    assign o_disp_rsp.prd       = rn_alloc ? fl_head_preg : '0;
    assign o_disp_rsp.rs1_ready = rs1_ready;
    assign o_disp_rsp.rs2_ready = rs2_ready;

    rename_rat u_rat (
        .clk,
        .rst,
        .i_rs1       (i_disp.rs1),
        .i_rs2       (i_disp.rs2),
        .i_rd        (i_disp.rd),
        .i_rename_en (rn_alloc),
        .i_new_prd   (fl_head_preg),
        .i_flush     (flush),
        .i_rrf_map   (rrf_map),
        .o_prs1      (rat_prs1),
        .o_prs2      (rat_prs2),
        .o_old_prd   (rat_old_prd)
    );

    rename_free_list u_free_list (
        .clk,
        .rst,
        .i_pop       (rn_alloc),
        .i_push      (free_push),
        .i_push_preg (free_preg),
        .i_flush     (flush),
        .o_head_preg (fl_head_preg)
    );

    rename_rob u_rob (
        .clk,
        .rst,
        .i_disp        (i_disp),
        .i_new_prd     (fl_head_preg),
        .i_old_prd     (rat_old_prd),
        .i_cdb         (i_cdb),
        .i_commit_data (commit_data),
        .o_rob_idx     (rob_idx),
        .o_alloc       (rn_alloc),
        .o_commit_en   (commit_en),
        .o_commit_rd   (commit_rd),
        .o_commit_prd  (commit_prd),
        .o_free_push   (free_push),
        .o_free_preg   (free_preg),
        .o_flush       (flush),
        .o_commit      (o_commit),
        .o_credit_ret  (o_credit_ret)
    );

    rename_rrf u_rrf (
        .clk,
        .rst,
        .i_commit_en (commit_en),
        .i_rd        (commit_rd),
        .i_prd       (commit_prd),
        .o_map       (rrf_map)
    );

    rename_ready_table u_ready_table (
        .clk,
        .rst,
        .i_alloc      (rn_alloc),
        .i_alloc_preg (fl_head_preg),
        .i_prs1       (rat_prs1),
        .i_prs2       (rat_prs2),
        .i_cdb        (i_cdb),
        .i_flush      (flush),
        .o_rs1_ready  (rs1_ready),
        .o_rs2_ready  (rs2_ready)
    );

    // Commit data comes straight from the head's destination register
    rename_prf u_prf (
        .clk,
        .rst,
        .i_cdb     (i_cdb),
        .i_rd_preg (commit_prd),
        .o_rd_data (commit_data)
    );

endmodule

`default_nettype wire

//--- rename_prf.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_prf (
    input  logic                  clk,
    input  logic                  rst,
    input  rename_pkg::cdb_t      i_cdb,
    input  rename_pkg::phys_idx_t i_rd_preg,
    output rename_pkg::xlen_t     o_rd_data
);
    import rename_pkg::*;

    xlen_t regs_q [`RN_PHYS_REGS];
    logic  wr_en;

    // No writes while in reset, and never to register 0
    assign wr_en = !rst && i_cdb.valid && (i_cdb.prd != '0);

    assign o_rd_data = (i_rd_preg == '0) ? '0 : regs_q[i_rd_preg];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs_q[i_cdb.prd] <= i_cdb.data;
        end
    end

endmodule

`default_nettype wire

//--- rename_ready_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_ready_table (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_alloc,
    input  rename_pkg::phys_idx_t i_alloc_preg,
    input  rename_pkg::phys_idx_t i_prs1,
    input  rename_pkg::phys_idx_t i_prs2,
    input  rename_pkg::cdb_t      i_cdb,
    input  logic                  i_flush,
    output logic                  o_rs1_ready,
    output logic                  o_rs2_ready
);
    import rename_pkg::*;

    logic [`RN_PHYS_REGS-1:0] ready_q;

    // Same cycle completion counts as ready
    assign o_rs1_ready = ready_q[i_prs1] || (i_cdb.valid && (i_cdb.prd == i_prs1));
    assign o_rs2_ready = ready_q[i_prs2] || (i_cdb.valid && (i_cdb.prd == i_prs2));

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            // Everything left after a flush has been committed
            ready_q <= '1;
        end else begin
            if (i_cdb.valid) begin
                ready_q[i_cdb.prd] <= 1'b1;
            end
            // Register 0 stays ready
            if (i_alloc && (i_alloc_preg != '0)) begin
                ready_q[i_alloc_preg] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rename_rrf.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_rrf (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_commit_en,
    input  rename_pkg::arch_idx_t i_rd,
    input  rename_pkg::phys_idx_t i_prd,
    output rename_pkg::phys_idx_t o_map [`RN_ARCH_REGS]
);
    import rename_pkg::*;

    phys_idx_t map_q [`RN_ARCH_REGS];

    // Forward the current commit so a flush restores an up to date map
    always_comb begin
        o_map = map_q;
        if (i_commit_en) begin
            o_map[i_rd] = i_prd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= phys_idx_t'(i);
            end
        end else if (i_commit_en) begin
            map_q[i_rd] <= i_prd;
        end
    end

endmodule

`default_nettype wire

//--- rename_rob.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_rob (
    input  logic                    clk,
    input  logic                    rst,
    input  rename_pkg::disp_req_t   i_disp,
    input  rename_pkg::phys_idx_t   i_new_prd,
    input  rename_pkg::phys_idx_t   i_old_prd,
    input  rename_pkg::cdb_t        i_cdb,
    input  rename_pkg::xlen_t       i_commit_data,
    output rename_pkg::rob_idx_t    o_rob_idx,
    output logic                    o_alloc,
    output logic                    o_commit_en,
    output rename_pkg::arch_idx_t   o_commit_rd,
    output rename_pkg::phys_idx_t   o_commit_prd,
    output logic                    o_free_push,
    output rename_pkg::phys_idx_t   o_free_preg,
    output logic                    o_flush,
    output rename_pkg::commit_t     o_commit,
    output rename_pkg::credit_cnt_t o_credit_ret
);
    import rename_pkg::*;

    // Slot payload
    arch_idx_t rd_q      [`RN_ROB_DEPTH];
    logic      renames_q [`RN_ROB_DEPTH];
    phys_idx_t new_prd_q [`RN_ROB_DEPTH];
    phys_idx_t old_prd_q [`RN_ROB_DEPTH];

    // Slot status
    logic [`RN_ROB_DEPTH-1:0] done_q;
    logic [`RN_ROB_DEPTH-1:0] redirect_q;

    rob_idx_t    head;
    rob_idx_t    tail;
    credit_cnt_t count;

    logic disp_fire;
    logic head_done;

    // A dispatch alongside a redirect commit is dropped
    assign disp_fire = i_disp.valid && !o_flush;
    assign o_alloc   = disp_fire && i_disp.writes_rd && (i_disp.rd != '0);
    assign o_rob_idx = tail;

    assign head_done = (count != '0) && done_q[head];

    assign o_commit_en  = head_done && renames_q[head];
    assign o_commit_rd  = rd_q[head];
    assign o_commit_prd = new_prd_q[head];
    assign o_free_push  = o_commit_en;
    assign o_free_preg  = old_prd_q[head];
    assign o_flush      = head_done && redirect_q[head];

    always_comb begin
        o_commit.valid     = head_done;
        o_commit.rd        = rd_q[head];
        o_commit.writes_rd = renames_q[head];
        o_commit.data      = i_commit_data;
        o_commit.redirect  = redirect_q[head];
    end

    // Redirect hands back the slot itself plus everything younger
    always_comb begin
        if (!head_done) begin
            o_credit_ret = '0;
        end else if (o_flush) begin
            o_credit_ret = count;
        end else begin
            o_credit_ret = credit_cnt_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (disp_fire) begin
            rd_q[tail]      <= i_disp.rd;
            renames_q[tail] <= o_alloc;
            new_prd_q[tail] <= o_alloc ? i_new_prd : '0;
            old_prd_q[tail] <= i_old_prd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q     <= '0;
            redirect_q <= '0;
        end else begin
            if (i_cdb.valid) begin
                done_q[i_cdb.rob_idx]     <= 1'b1;
                redirect_q[i_cdb.rob_idx] <= i_cdb.redirect;
            end
            if (disp_fire) begin
                done_q[tail]     <= 1'b0;
                redirect_q[tail] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || o_flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (disp_fire) begin
                tail <= tail + 1'b1;
            end
            if (head_done) begin
                head <= head + 1'b1;
            end
            count <= count + credit_cnt_t'(disp_fire) - credit_cnt_t'(head_done);
        end
    end

endmodule

`default_nettype wire

//--- rename_free_list.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_free_list (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_pop,
    input  logic                  i_push,
    input  rename_pkg::phys_idx_t i_push_preg,
    input  logic                  i_flush,
    output rename_pkg::phys_idx_t o_head_preg
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(`RN_ROB_DEPTH);

    phys_idx_t        fifo_q [`RN_ROB_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_ptr_nxt;

    assign o_head_preg = fifo_q[rd_ptr];
    assign wr_ptr_nxt  = i_push ? wr_ptr + 1'b1 : wr_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Starts full with the registers beyond the identity map
            for (int i = 0; i < `RN_ROB_DEPTH; i++) begin
                fifo_q[i] <= phys_idx_t'(`RN_ARCH_REGS + i);
            end
        end else if (i_push) begin
            fifo_q[wr_ptr] <= i_push_preg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr_nxt;
            if (i_flush) begin
                // Slots between the pointers still hold the registers
                // popped by the squashed instructions, so the queue is full again
                rd_ptr <= wr_ptr_nxt;
            end else if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rename_rat.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_consts.svh"

module rename_rat (
    input  logic                clk,
    input  logic                rst,
    input  rename_pkg::arch_idx_t i_rs1,
    input  rename_pkg::arch_idx_t i_rs2,
    input  rename_pkg::arch_idx_t i_rd,
    input  logic                i_rename_en,
    input  rename_pkg::phys_idx_t i_new_prd,
    input  logic                i_flush,
    input  rename_pkg::phys_idx_t i_rrf_map [`RN_ARCH_REGS],
    output rename_pkg::phys_idx_t o_prs1,
    output rename_pkg::phys_idx_t o_prs2,
    output rename_pkg::phys_idx_t o_old_prd
);
    import rename_pkg::*;

    phys_idx_t map_q [`RN_ARCH_REGS];

    // Lookups see the map before this cycle's update,
    // so a source that matches rd gets the old mapping
    assign o_prs1    = map_q[i_rs1];
    assign o_prs2    = map_q[i_rs2];
    assign o_old_prd = map_q[i_rd];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= phys_idx_t'(i);
            end
        end else if (i_flush) begin
            // Roll back to the committed map
            map_q <= i_rrf_map;
        end else if (i_rename_en) begin
            map_q[i_rd] <= i_new_prd;
        end
    end

endmodule

`default_nettype wire

//--- rename_pkg.sv
`default_nettype none

`include "rename_consts.svh"

package rename_pkg;

    typedef logic [$clog2(`RN_ARCH_REGS)-1:0]   arch_idx_t;
    typedef logic [$clog2(`RN_PHYS_REGS)-1:0]   phys_idx_t;
    typedef logic [$clog2(`RN_ROB_DEPTH)-1:0]   rob_idx_t;
    // Needs to hold a full ROB worth of credits
    typedef logic [$clog2(`RN_ROB_DEPTH+1)-1:0] credit_cnt_t;
    typedef logic [`RN_XLEN-1:0]                xlen_t;

    typedef struct packed {
        logic      valid;
        arch_idx_t rs1;
        arch_idx_t rs2;
        arch_idx_t rd;
        logic      writes_rd;
    } disp_req_t;

    typedef struct packed {
        rob_idx_t  rob_idx;
        phys_idx_t prs1;
        phys_idx_t prs2;
        phys_idx_t prd;
        logic      rs1_ready;
        logic      rs2_ready;
    } disp_rsp_t;

    // Completion bus, one result per cycle
    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        phys_idx_t prd;
        xlen_t     data;
        logic      redirect;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        arch_idx_t rd;
        logic      writes_rd;
        xlen_t     data;
        logic      redirect;
    } commit_t;

endpackage

`default_nettype wire

//--- rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Architectural register count of RV32I
`define RN_ARCH_REGS 32

// Reorder buffer slots, one dispatch credit each
`define RN_ROB_DEPTH 16

// One spare physical register per ROB slot
// so the free list never runs dry while credits remain
`define RN_PHYS_REGS 48

// Data word width
`define RN_XLEN 32

`endif
